// ==== bench/tb_tasks.svh ====
// directed tests for scrambling, seed recovery, bypass and gaps, lock hunt and lock loss

function automatic logic [pcs_pkg::HEADER_BITS-1:0] random_valid_header();
	rng_state = xorshift32(rng_state);
	return rng_state[0] ? pcs_pkg::SYNC_DATA : pcs_pkg::SYNC_CTRL;
endfunction

// 00 or 11 is never legal on the line
function automatic logic [pcs_pkg::HEADER_BITS-1:0] invalid_header();
	rng_state = xorshift32(rng_state);
	return rng_state[0] ? 2'b00 : 2'b11;
endfunction

task automatic check_link(input logic lock_expected);
	assert (o_block_lock === lock_expected)
	else report_value_error("o_block_lock", o_block_lock, lock_expected);
	assert (o_header_errors === 16'(invalid_sent))
	else report_value_error("o_header_errors", o_header_errors, invalid_sent);
endtask

// back to back scrambled blocks
// 100 valid headers also reach lock
task automatic scramble_after_reset();
	apply_reset();
	for (int i = 0; i < 100; i++)
		send_block(1'b0, random_valid_header());
	drain_pipeline();
	check_link(1'b1);
endtask

// wrong rx seed so the first block is skipped
// the rest must match the input
task automatic seed_mismatch_recovery();
	apply_reset();
	for (int i = 0; i < 20; i++)
		send_block(1'b0, random_valid_header());
	drain_pipeline();
endtask

// bypass singles and a bypass pair with idle gaps in between
task automatic bypass_and_gaps();
	for (int i = 0; i < 24; i++)
	begin
		send_block((i % 5 == 2) || (i == 13), random_valid_header());
		if (i % 7 == 3)
			idle_cycles(2);
	end
	drain_pipeline();
endtask

// bad header after 40 good ones restarts the hunt
task automatic lock_acquire_restart();
	apply_reset();
	for (int i = 0; i < 40; i++)
		send_block(1'b0, random_valid_header());
	send_block(1'b0, invalid_header());
	for (int i = 0; i < LOCK_COUNT - 1; i++)
		send_block(1'b0, random_valid_header());
	drain_pipeline();
	check_link(1'b0);
	// 64th good header since the error
	send_block(1'b0, random_valid_header());
	drain_pipeline();
	check_link(1'b1);
endtask

// window one stays under the limit and window two reaches it
task automatic lock_loss_window();
	for (int i = 0; i < WINDOW_BLOCKS; i++)
		send_block(1'b0, (i % 4 == 0 && i / 4 < LOSS_COUNT - 1) ?
			invalid_header() : random_valid_header());
	drain_pipeline();
	check_link(1'b1);
	for (int i = 0; i < WINDOW_BLOCKS; i++)
	begin
		// window one errors are gone so 15 more still keep lock
		if (i == 4 * (LOSS_COUNT - 1))
		begin
			drain_pipeline();
			check_link(1'b1);
		end
		send_block(1'b0, (i % 4 == 0 && i / 4 < LOSS_COUNT) ?
			invalid_header() : random_valid_header());
	end
	drain_pipeline();
	check_link(1'b0);
endtask

// ==== bench/tb_pcs_scramble_loop.sv ====
// testbench top with clock, reset, DUT, serial scrambler model and output checker
`default_nettype none
`timescale 1ns/1ps

module tb_pcs_scramble_loop;

	localparam logic [pcs_pkg::SCRAMBLER_BITS-1:0] TX_SEED = 58'h1b7_4c2e_9a05_d3f6;
	// descrambler starts wrong on purpose
	localparam logic [pcs_pkg::SCRAMBLER_BITS-1:0] RX_SEED = '0;
	localparam int LOCK_COUNT    = 64;
	localparam int LOSS_COUNT    = 16;
	localparam int WINDOW_BLOCKS = 64;
	// blocks over all five tests
	// idle gaps and drains fit in the margin
	localparam int TOTAL_BLOCKS  = 380;
	localparam int MAX_CYCLES    = 2 * TOTAL_BLOCKS + 200;

	logic                            i_clock;
	logic                            i_reset;
	logic                            i_enable;
	logic                            i_bypass;
	logic [pcs_pkg::BLOCK_BITS-1:0]  i_data;
	logic                            o_line_valid;
	logic [pcs_pkg::BLOCK_BITS-1:0]  o_line_data;
	logic                            o_valid;
	logic [pcs_pkg::BLOCK_BITS-1:0]  o_data;
	logic                            o_block_lock;
	logic [15:0]                     o_header_errors;

	// reference scrambler history with the newest output bit at 0
	logic [pcs_pkg::SCRAMBLER_BITS-1:0] model_state;
	logic [31:0]                        rng_state;
	int                                 cycle_count = 0;
	int                                 invalid_sent;
	// set by the first scrambled block after reset
	bit                                 rx_synced;

	// expected blocks and the counter value at which each must show up
	logic [pcs_pkg::BLOCK_BITS-1:0] line_exp_q[$];
	int                             line_when_q[$];
	logic [pcs_pkg::BLOCK_BITS-1:0] out_exp_q[$];
	int                             out_when_q[$];
	bit                             out_check_q[$];

	pcs_scramble_loop
	#(
		.TX_SEED       (TX_SEED),
		.RX_SEED       (RX_SEED),
		.LOCK_COUNT    (LOCK_COUNT),
		.LOSS_COUNT    (LOSS_COUNT),
		.WINDOW_BLOCKS (WINDOW_BLOCKS)
	)
	pcs_scramble_loop_inst
	(
		.i_clock         (i_clock),
		.i_reset         (i_reset),
		.i_enable        (i_enable),
		.i_bypass        (i_bypass),
		.i_data          (i_data),
		.o_line_valid    (o_line_valid),
		.o_line_data     (o_line_data),
		.o_valid         (o_valid),
		.o_data          (o_data),
		.o_block_lock    (o_block_lock),
		.o_header_errors (o_header_errors)
	);

	// 10 ns clock
	initial
	begin
		i_clock = 1'b0;
		forever
			#5 i_clock = ~i_clock;
	end

	// cycle counter and run limit
	always @(posedge i_clock)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES)
			report_failure("timeout, the tests did not finish within the cycle limit");
	end

	task automatic report_value_error(input string name,
		input logic [pcs_pkg::BLOCK_BITS-1:0] got, input logic [pcs_pkg::BLOCK_BITS-1:0] expected);
		$display("ERR %s got 0x%0h expected 0x%0h", name, got, expected);
		$display("Simulation failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic report_failure(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1, "stopped at the first error");
	endtask

	// 32-bit xorshift with shifts 13 17 5
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// serial rule from the payload msb down
	// out = in ^ out 39 bits back ^ out 58 bits back
	function automatic logic [pcs_pkg::PAYLOAD_BITS-1:0] scramble_model(
		input logic [pcs_pkg::PAYLOAD_BITS-1:0] plain);
		logic [pcs_pkg::PAYLOAD_BITS-1:0] line;
		logic                             bit_out;
		for (int n = pcs_pkg::PAYLOAD_BITS - 1; n >= 0; n--)
		begin
			bit_out = plain[n] ^ model_state[pcs_pkg::SCRAMBLER_TAP-1] ^
				model_state[pcs_pkg::SCRAMBLER_BITS-1];
			line[n] = bit_out;
			model_state = {model_state[pcs_pkg::SCRAMBLER_BITS-2:0], bit_out};
		end
		return line;
	endfunction

	// one block on the next rising edge
	// expectations go into the queues with their due cycle
	task automatic send_block(input bit bypass, input logic [pcs_pkg::HEADER_BITS-1:0] header);
		logic [pcs_pkg::PAYLOAD_BITS-1:0] payload;
		logic [pcs_pkg::PAYLOAD_BITS-1:0] line_payload;
		bit                               check_out;
		rng_state = xorshift32(rng_state);
		payload[63:32] = rng_state;
		rng_state = xorshift32(rng_state);
		payload[31:0] = rng_state;
		// model state holds across bypass
		line_payload = bypass ? payload : scramble_model(payload);
		// only the first scrambled block after reset sees the wrong rx seed
		check_out = bypass || rx_synced;
		if (!bypass)
			rx_synced = 1'b1;
		if (header != pcs_pkg::SYNC_DATA && header != pcs_pkg::SYNC_CTRL)
			invalid_sent++;
		@(posedge i_clock);
		i_enable <= 1'b1;
		i_bypass <= bypass;
		i_data   <= {header, payload};
		// counter still shows the previous edge here
		line_exp_q.push_back({header, line_payload});
		line_when_q.push_back(cycle_count + 2);
		out_exp_q.push_back({header, payload});
		out_when_q.push_back(cycle_count + 3);
		out_check_q.push_back(check_out);
	endtask

	task automatic idle_cycles(input int count);
		repeat (count)
		begin
			@(posedge i_clock);
			i_enable <= 1'b0;
			i_bypass <= 1'b0;
		end
	endtask

	// stop sending and wait until the last block has left the descrambler
	task automatic drain_pipeline();
		@(posedge i_clock);
		i_enable <= 1'b0;
		i_bypass <= 1'b0;
		while (out_when_q.size() > 0)
			@(negedge i_clock);
		@(negedge i_clock);
	endtask

	// 4 cycles of reset and then idle outputs
	task automatic apply_reset();
		@(posedge i_clock);
		i_reset  <= 1'b1;
		i_enable <= 1'b0;
		i_bypass <= 1'b0;
		line_exp_q.delete();
		line_when_q.delete();
		out_exp_q.delete();
		out_when_q.delete();
		out_check_q.delete();
		model_state  = TX_SEED;
		rx_synced    = 1'b0;
		invalid_sent = 0;
		repeat (3)
			@(posedge i_clock);
		@(posedge i_clock);
		i_reset <= 1'b0;
		@(negedge i_clock);
		assert (o_valid === 1'b0) else report_value_error("o_valid", o_valid, 0);
		assert (o_line_valid === 1'b0) else report_value_error("o_line_valid", o_line_valid, 0);
		assert (o_block_lock === 1'b0) else report_value_error("o_block_lock", o_block_lock, 0);
		assert (o_header_errors === 16'h0)
		else report_value_error("o_header_errors", o_header_errors, 0);
		assert (o_data === '0) else report_value_error("o_data", o_data, 0);
		assert (o_line_data === '0) else report_value_error("o_line_data", o_line_data, 0);
	endtask

	// compare both strobed outputs against the queues in mid cycle
	task automatic check_outputs();
		logic [pcs_pkg::BLOCK_BITS-1:0] expected;
		bit                             compare;
		if (line_when_q.size() > 0 && line_when_q[0] == cycle_count)
		begin
			assert (o_line_valid === 1'b1)
			else report_failure("o_line_valid did not rise one cycle after i_enable");
			expected = line_exp_q.pop_front();
			line_when_q.delete(0);
			assert (o_line_data === expected)
			else report_value_error("o_line_data", o_line_data, expected);
		end
		else
			assert (o_line_valid === 1'b0)
			else report_failure("o_line_valid rose without a block sent one cycle before");
		if (out_when_q.size() > 0 && out_when_q[0] == cycle_count)
		begin
			assert (o_valid === 1'b1)
			else report_failure("o_valid did not rise two cycles after i_enable");
			expected = out_exp_q.pop_front();
			out_when_q.delete(0);
			compare = out_check_q.pop_front();
			if (compare)
				assert (o_data === expected) else report_value_error("o_data", o_data, expected);
		end
		else
			assert (o_valid === 1'b0)
			else report_failure("o_valid rose without a block sent two cycles before");
	endtask

	always @(negedge i_clock)
	begin
		if (!i_reset)
			check_outputs();
	end

	`include "tb_tasks.svh"

	initial
	begin
		i_reset   = 1'b1;
		i_enable  = 1'b0;
		i_bypass  = 1'b0;
		i_data    = '0;
		rng_state = 32'he5a2c4e1;
		scramble_after_reset();
		seed_mismatch_recovery();
		bypass_and_gaps();
		lock_acquire_restart();
		lock_loss_window();
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

// ==== hdl/block_descrambler.sv ====
// block_descrambler, parallel self-synchronizing receive descrambler with bypass
`default_nettype none
`timescale 1ns/1ps

module block_descrambler
#(
	parameter logic [pcs_pkg::SCRAMBLER_BITS-1:0] RX_SEED = '0
)
(
	input  wire                              i_clock,
	input  wire                              i_reset,
	coded_block_if.sink                      i_line,
	output logic                             o_valid,
	output logic [pcs_pkg::BLOCK_BITS-1:0]   o_data
);

	// same split as the transmit side, 39 + 19 + 6
	localparam int STAGE_ONE   = pcs_pkg::SCRAMBLER_TAP;
	localparam int STAGE_TWO   = pcs_pkg::SCRAMBLER_BITS - pcs_pkg::SCRAMBLER_TAP;
	localparam int STAGE_THREE = pcs_pkg::PAYLOAD_BITS - pcs_pkg::SCRAMBLER_BITS;

	localparam int PB  = pcs_pkg::PAYLOAD_BITS;
	localparam int SB  = pcs_pkg::SCRAMBLER_BITS;
	localparam int TAP = pcs_pkg::SCRAMBLER_TAP;

	// last 58 received line bits, newest at bit 0
	logic [SB-1:0]          descrambler_state;
	logic [PB-1:0]          line_payload;
	logic [STAGE_ONE-1:0]   stage_one;
	logic [STAGE_TWO-1:0]   stage_two;
	logic [STAGE_THREE-1:0] stage_three;
	logic [PB-1:0]          plain_payload;

	assign line_payload = i_line.payload;

	// plain bit n = line n ^ line n-39 ^ line n-58
	// history is line bits, so no output feeds back
	// stage one, taps from stored line bits
	always_comb
	begin
		for (int i = 0; i < STAGE_ONE; i++)
			stage_one[STAGE_ONE-1-i] = line_payload[PB-1-i] ^
				descrambler_state[TAP-1-i] ^ descrambler_state[SB-1-i];
	end

	// stage two, x^39 tap from this block's line bits
	always_comb
	begin
		for (int j = 0; j < STAGE_TWO; j++)
			stage_two[STAGE_TWO-1-j] = line_payload[PB-1-TAP-j] ^
				line_payload[PB-1-j] ^ descrambler_state[SB-1-TAP-j];
	end

	// stage three, both taps inside this block
	always_comb
	begin
		for (int k = 0; k < STAGE_THREE; k++)
			stage_three[STAGE_THREE-1-k] = line_payload[PB-1-SB-k] ^
				line_payload[PB-1-STAGE_TWO-k] ^ line_payload[PB-1-k];
	end

	assign plain_payload = {stage_one, stage_two, stage_three};

	// state loads raw line bits
	// after one full block any seed error is gone
	always_ff @(posedge i_clock)
	begin
		if (i_reset)
			descrambler_state <= RX_SEED;
		else if (i_line.enable && !i_line.bypass)
			descrambler_state <= line_payload[SB-1:0];
	end

	// recovered block one cycle after the line strobe
	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			o_valid <= 1'b0;
			o_data  <= '0;
		end
		else
		begin
			o_valid <= i_line.enable;
			if (i_line.enable)
				o_data <= {i_line.header, i_line.bypass ? line_payload : plain_payload};
		end
	end

	// no repeated valid unless a new line block arrived
	assert property (@(posedge i_clock) disable iff (i_reset)
		(o_valid && !i_line.enable) |=> !o_valid);

endmodule

`default_nettype wire

// ==== hdl/block_scrambler.sv ====
// block_scrambler, parallel transmit scrambler for 1 + x^39 + x^58 with seed and bypass
`default_nettype none
`timescale 1ns/1ps

module block_scrambler
#(
	parameter logic [pcs_pkg::SCRAMBLER_BITS-1:0] TX_SEED = '0
)
(
	input  wire                              i_clock,
	input  wire                              i_reset,
	input  wire                              i_enable,
	input  wire                              i_bypass,
	input  wire  [pcs_pkg::BLOCK_BITS-1:0]   i_data,
	coded_block_if.source                    o_line
);

	// stage widths, 39 + 19 + 6 = 64
	localparam int STAGE_ONE   = pcs_pkg::SCRAMBLER_TAP;
	localparam int STAGE_TWO   = pcs_pkg::SCRAMBLER_BITS - pcs_pkg::SCRAMBLER_TAP;
	localparam int STAGE_THREE = pcs_pkg::PAYLOAD_BITS - pcs_pkg::SCRAMBLER_BITS;

	localparam int PB  = pcs_pkg::PAYLOAD_BITS;
	localparam int SB  = pcs_pkg::SCRAMBLER_BITS;
	localparam int TAP = pcs_pkg::SCRAMBLER_TAP;

	// last 58 output bits, newest at bit 0
	logic [SB-1:0]          scrambler_state;
	logic [PB-1:0]          plain_payload;
	logic [STAGE_ONE-1:0]   stage_one;
	logic [STAGE_TWO-1:0]   stage_two;
	logic [STAGE_THREE-1:0] stage_three;
	logic [PB-1:0]          scrambled_payload;

	// header passes through, only the payload is scrambled
	assign plain_payload = i_data[PB-1:0];

	// output bit n = input n ^ output n-39 ^ output n-58, n = 0 at payload msb
	// stage one, both taps still in the stored state
	always_comb
	begin
		for (int i = 0; i < STAGE_ONE; i++)
			stage_one[STAGE_ONE-1-i] = plain_payload[PB-1-i] ^
				scrambler_state[TAP-1-i] ^ scrambler_state[SB-1-i];
	end

	// stage two, the x^39 tap falls on stage one outputs
	always_comb
	begin
		for (int j = 0; j < STAGE_TWO; j++)
			stage_two[STAGE_TWO-1-j] = plain_payload[PB-1-TAP-j] ^
				stage_one[STAGE_ONE-1-j] ^ scrambler_state[SB-1-TAP-j];
	end

	// stage three, both taps fall on stage one outputs
	always_comb
	begin
		for (int k = 0; k < STAGE_THREE; k++)
			stage_three[STAGE_THREE-1-k] = plain_payload[PB-1-SB-k] ^
				stage_one[STAGE_ONE-1-STAGE_TWO-k] ^ stage_one[STAGE_ONE-1-k];
	end

	assign scrambled_payload = {stage_one, stage_two, stage_three};

	// polynomial state, held in bypass and between blocks
	always_ff @(posedge i_clock)
	begin
		if (i_reset)
			scrambler_state <= TX_SEED;
		else if (i_enable && !i_bypass)
			// newest 58 outputs are the low payload bits
			scrambler_state <= scrambled_payload[SB-1:0];
	end

	// line block, one cycle after the input strobe
	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			o_line.enable  <= 1'b0;
			o_line.bypass  <= 1'b0;
			o_line.header  <= '0;
			o_line.payload <= '0;
		end
		else
		begin
			o_line.enable <= i_enable;
			// data holds while enable is low
			if (i_enable)
			begin
				o_line.bypass  <= i_bypass;
				o_line.header  <= i_data[pcs_pkg::BLOCK_BITS-1:PB];
				o_line.payload <= i_bypass ? plain_payload : scrambled_payload;
			end
		end
	end

	// every input strobe gives exactly one line strobe a cycle later
	assert property (@(posedge i_clock) disable iff (i_reset)
		i_enable |=> o_line.enable);
	assert property (@(posedge i_clock) disable iff (i_reset)
		o_line.enable |-> $past(i_enable));

endmodule

`default_nettype wire

// ==== hdl/coded_block_if.sv ====
// coded_block_if interface, one 66-bit coded block with enable strobe and bypass level
`default_nettype none
`timescale 1ns/1ps

interface coded_block_if;

	// one block per pulse, no ready
	logic enable;
	// block travels unscrambled, polynomial state holds
	logic bypass;
	// sync header, never scrambled
	logic [pcs_pkg::HEADER_BITS-1:0] header;
	// 64 payload bits, msb is the first bit on the line
	logic [pcs_pkg::PAYLOAD_BITS-1:0] payload;

	// block producer
	modport source
	(
		output enable,
		output bypass,
		output header,
		output payload
	);

	// block consumers
	modport sink
	(
		input enable,
		input bypass,
		input header,
		input payload
	);

endinterface

`default_nettype wire

// ==== hdl/pcs_pkg.sv ====
// block widths, scrambler polynomial taps and sync header codes for the 64b/66b PCS
`default_nettype none

package pcs_pkg;

	// one coded block is a 2-bit sync header above a 64-bit payload
	localparam int BLOCK_BITS   = 66;
	localparam int PAYLOAD_BITS = 64;
	localparam int HEADER_BITS  = 2;

	// polynomial 1 + x^39 + x^58
	// state length is the highest power
	localparam int SCRAMBLER_BITS = 58;
	// inner tap distance
	localparam int SCRAMBLER_TAP  = 39;

	// valid sync headers
	// data block, all eight payload bytes are data
	localparam logic [HEADER_BITS-1:0] SYNC_DATA = 2'b01;
	// control block, first payload byte is a block type field
	localparam logic [HEADER_BITS-1:0] SYNC_CTRL = 2'b10;

	// 00 and 11 are never sent and count as header errors

endpackage

`default_nettype wire

// ==== hdl/pcs_scramble_loop.sv ====
// pcs_scramble_loop, loopback of scrambler, descrambler and sync header monitor
`default_nettype none
`timescale 1ns/1ps

module pcs_scramble_loop
#(
	// scrambler start state, any value but zero keeps the line busy
	parameter logic [pcs_pkg::SCRAMBLER_BITS-1:0] TX_SEED = 58'h3ff_ffff_ffff_ffff,
	// descrambler start state, need not match
	parameter logic [pcs_pkg::SCRAMBLER_BITS-1:0] RX_SEED = 58'h3ff_ffff_ffff_ffff,
	// lock hunt length
	parameter int LOCK_COUNT    = 64,
	// errors per window that drop lock
	parameter int LOSS_COUNT    = 16,
	parameter int WINDOW_BLOCKS = 64
)
(
	input  wire                              i_clock,
	input  wire                              i_reset,
	// transmit side, one coded block per strobe
	input  wire                              i_enable,
	input  wire                              i_bypass,
	input  wire  [pcs_pkg::BLOCK_BITS-1:0]   i_data,
	// scrambled line block, 1 cycle after i_enable
	output logic                             o_line_valid,
	output logic [pcs_pkg::BLOCK_BITS-1:0]   o_line_data,
	// recovered block, 2 cycles after i_enable
	output logic                             o_valid,
	output logic [pcs_pkg::BLOCK_BITS-1:0]   o_data,
	// receive link status
	output logic                             o_block_lock,
	output logic [15:0]                      o_header_errors
);

	// line side, one driver and two readers
	coded_block_if line_if ();

	// transmit scrambler
	block_scrambler
	#(
		.TX_SEED (TX_SEED)
	)
	block_scrambler_inst
	(
		.i_clock  (i_clock),
		.i_reset  (i_reset),
		.i_enable (i_enable),
		.i_bypass (i_bypass),
		.i_data   (i_data),
		.o_line   (line_if.source)
	);

	// receive descrambler
	block_descrambler
	#(
		.RX_SEED (RX_SEED)
	)
	block_descrambler_inst
	(
		.i_clock (i_clock),
		.i_reset (i_reset),
		.i_line  (line_if.sink),
		.o_valid (o_valid),
		.o_data  (o_data)
	);

	// header check and lock, in parallel with the descrambler
	sync_header_monitor
	#(
		.LOCK_COUNT    (LOCK_COUNT),
		.LOSS_COUNT    (LOSS_COUNT),
		.WINDOW_BLOCKS (WINDOW_BLOCKS)
	)
	sync_header_monitor_inst
	(
		.i_clock         (i_clock),
		.i_reset         (i_reset),
		.i_line          (line_if.sink),
		.o_block_lock    (o_block_lock),
		.o_header_errors (o_header_errors)
	);

	// line block made visible for checking
	assign o_line_valid = line_if.enable;
	assign o_line_data  = {line_if.header, line_if.payload};

endmodule

`default_nettype wire

// ==== hdl/sync_header_monitor.sv ====
// sync_header_monitor, invalid header counter and block lock FSM on aligned line blocks
`default_nettype none
`timescale 1ns/1ps

module sync_header_monitor
#(
	parameter int LOCK_COUNT    = 64,
	parameter int LOSS_COUNT    = 16,
	parameter int WINDOW_BLOCKS = 64
)
(
	input  wire          i_clock,
	input  wire          i_reset,
	coded_block_if.sink  i_line,
	output logic         o_block_lock,
	output logic [15:0]  o_header_errors
);

	localparam int RUN_BITS    = $clog2(LOCK_COUNT + 1);
	localparam int LOSS_BITS   = $clog2(LOSS_COUNT + 1);
	localparam int WINDOW_BITS = $clog2(WINDOW_BLOCKS + 1);

	typedef enum logic
	{
		ST_UNLOCKED,
		ST_LOCKED
	} lock_state_t;

	lock_state_t            lock_state;
	// consecutive good headers while hunting
	logic [RUN_BITS-1:0]    valid_run;
	// blocks seen in the current window
	logic [WINDOW_BITS-1:0] window_count;
	// bad headers seen in the current window
	logic [LOSS_BITS-1:0]   window_errors;
	logic                   header_valid;
	logic                   header_error;

	// only 01 and 10 are legal
	assign header_valid = (i_line.header == pcs_pkg::SYNC_DATA) ||
		(i_line.header == pcs_pkg::SYNC_CTRL);
	assign header_error = i_line.enable && !header_valid;

	assign o_block_lock = (lock_state == ST_LOCKED);

	// lock hunt and loss detection
	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			lock_state    <= ST_UNLOCKED;
			valid_run     <= '0;
			window_count  <= '0;
			window_errors <= '0;
		end
		else if (i_line.enable)
		begin
			case (lock_state)
				ST_UNLOCKED:
				begin
					if (!header_valid)
						// one bad header restarts the hunt
						valid_run <= '0;
					else if (valid_run == RUN_BITS'(LOCK_COUNT - 1))
					begin
						lock_state    <= ST_LOCKED;
						valid_run     <= '0;
						// first window starts on the next block
						window_count  <= '0;
						window_errors <= '0;
					end
					else
						valid_run <= valid_run + 1'b1;
				end
				ST_LOCKED:
				begin
					if (!header_valid && window_errors == LOSS_BITS'(LOSS_COUNT - 1))
					begin
						// too many errors in this window
						lock_state <= ST_UNLOCKED;
						valid_run  <= '0;
					end
					else if (window_count == WINDOW_BITS'(WINDOW_BLOCKS - 1))
					begin
						// window end, fresh count
						window_count  <= '0;
						window_errors <= '0;
					end
					else
					begin
						window_count <= window_count + 1'b1;
						if (!header_valid)
							window_errors <= window_errors + 1'b1;
					end
				end
				default:
					lock_state <= ST_UNLOCKED;
			endcase
		end
	end

	// total bad headers, sticks at all ones
	always_ff @(posedge i_clock)
	begin
		if (i_reset)
			o_header_errors <= '0;
		else if (header_error && o_header_errors != 16'hffff)
			o_header_errors <= o_header_errors + 1'b1;
	end

	// error count is monotonic outside reset
	assert property (@(posedge i_clock) disable iff (i_reset)
		!$past(i_reset) |-> o_header_errors >= $past(o_header_errors));

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+bench
hdl/pcs_pkg.sv
hdl/coded_block_if.sv
hdl/block_scrambler.sv
hdl/block_descrambler.sv
hdl/sync_header_monitor.sv
hdl/pcs_scramble_loop.sv
bench/tb_pcs_scramble_loop.sv
